//--- sources.f
hdl/pov_pkg.sv
hdl/hall_sensor_emulator.sv
hdl/caterpillar_pattern.sv
hdl/led_driver_controller.sv
hdl/column_mux.sv
hdl/pov_display_top.sv
verification/pov_display_properties.sv
verification/pov_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the POV display testbench with Verilator, runs it into a log
# and decides pass or fail from that log
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module pov_display_tb \
    --Mdir "$build_dir" \
    -o pov_display_sim \
    -f sources.f

# Keep the simulator status so the log is always shown and searched
sim_status=0
"./$build_dir/pov_display_sim" +verilator+error+limit+1000 > "$log_file" 2>&1 || sim_status=$?
cat "$log_file"

if grep -qx "TEST OK" "$log_file" && [ "$sim_status" -eq 0 ]; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log_file"
exit 1

//--- verification/pov_display_tb.sv
/*
 * POV display testbench
 * Runs a table of frame sequences through the display subsystem, rebuilds
 * the serial words from the driver pins and compares them, the latch timing
 * and the column select with a model driven by the count of latched frames
 */
module pov_display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pov_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int num_tests    = 5;

    typedef struct {
        string name;
        int    frames;
        bit    mid_reset;
    } test_row_t;

    // Each row runs a number of frames, some of them after a reset that
    // lands at a random point inside a running frame
    // The long row passes frame 192 after its reset, where the dot wraps
    test_row_t test_table [num_tests] = '{
        '{name: "column_rotation",  frames: 8,   mid_reset: 1'b0},
        '{name: "pattern_progress", frames: 16,  mid_reset: 1'b0},
        '{name: "reset_mid_frame",  frames: 12,  mid_reset: 1'b1},
        '{name: "index_wrap",       frames: 200, mid_reset: 1'b0},
        '{name: "reset_recovery",   frames: 6,   mid_reset: 1'b1}
    };

    logic        clk_enable = 1'b0;
    logic        nrst;
    driver_bus_t drv;
    column_sel_t mux_out;
    logic        driver_ready;

    // Frames latched since the last reset set the expected index and column
    int   model_frames = 0;
    // The first frame after a reset waits a whole sync period
    bit   frame_after_reset = 1'b0;
    int   check_count  = 0;
    int   error_count  = 0;
    int   test_fails   = 0;
    int   failed_tests = 0;
    int   tests_run    = 0;
    // Grayscale clock bookkeeping
    int   gclk_cycles  = 0;
    int   gclk_toggles = 0;
    logic gclk_prev    = 1'b0;
    logic nrst_prev    = 1'b0;

    pov_display_top uut (
        .clk_enable   (clk_enable),
        .nrst         (nrst),
        .drv          (drv),
        .mux_out      (mux_out),
        .driver_ready (driver_ready)
    );

    always #20 clk_enable = ~clk_enable;

    // gclk should flip on every cycle that is fully out of reset
    always @(negedge clk_enable) begin
        if (nrst && nrst_prev) begin
            gclk_cycles++;
            if (drv.gclk !== gclk_prev) begin
                gclk_toggles++;
            end
        end
        gclk_prev = drv.gclk;
        nrst_prev = nrst;
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_fails++;
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string test_name, input string text);
        error_count++;
        test_fails++;
        $display("ERROR %s: %s", test_name, text);
    endtask

    // Waits on falling edges until the controller leaves idle
    // The falling edges counted after the first one come back in waited
    task automatic wait_frame_start(input string test_name, output bit started,
                                    output int waited);
        waited = 0;
        @(negedge clk_enable);
        while (driver_ready && waited < 2 * sync_period) begin
            @(negedge clk_enable);
            waited++;
        end
        started = !driver_ready;
        if (!started) begin
            report_error(test_name, "no frame started within two sync periods");
        end
    endtask

    // Holds nrst low for reset_cycles and checks the pins while it is low
    task automatic pulse_reset(input string test_name, input bit inside_frame);
        int offset;
        int idle_cycles;
        bit started;
        if (inside_frame) begin
            offset = int'($urandom_range(sync_period - 1, 0));
            wait_frame_start(test_name, started, idle_cycles);
            repeat (offset) @(posedge clk_enable);
        end
        @(posedge clk_enable);
        nrst <= 1'b0;
        @(negedge clk_enable);
        check_value(test_name, "driver bus in reset", 64'(0), 64'(drv));
        check_value(test_name, "mux_out in reset", 64'(1), 64'(mux_out));
        check_value(test_name, "driver_ready in reset", 64'(1), 64'(driver_ready));
        repeat (reset_cycles) @(posedge clk_enable);
        nrst <= 1'b1;
        model_frames      = 0;
        frame_after_reset = 1'b1;
    endtask

    // Follows one frame from the first setup cycle to the return to idle
    task automatic run_frame(input string test_name);
        sin_bus_t     samples [word_bits];
        column_word_t line_word;
        column_word_t expected_word;
        column_sel_t  expected_sel;
        int           expected_index;
        int           expected_idle;
        int           idle_cycles;
        int           sclk_edges;
        int           lat_cycle;
        int           cycles;
        int           after_lat;
        logic         prev_sclk;
        bit           started;

        // The dot moves every pattern_step frames and wraps after 48 channels
        expected_index = (model_frames / pattern_step) % word_bits;
        expected_word  = '0;
        expected_word[expected_index] = 1'b1;
        expected_sel   = '0;
        expected_sel[model_frames % num_columns] = 1'b1;
        for (int b = 0; b < word_bits; b++) begin
            samples[b] = '0;
        end

        wait_frame_start(test_name, started, idle_cycles);
        if (!started) begin
            return;
        end

        // Frames start one sync period apart
        // The last frame used 2 * word_bits + 2 cycles and one idle cycle
        // passed before the count began, while after reset the first frame
        // needs the whole period
        if (frame_after_reset) begin
            expected_idle = sync_period;
        end else begin
            expected_idle = sync_period - 2 * word_bits - 3;
        end
        frame_after_reset = 1'b0;
        check_value(test_name, "idle cycles before frame start",
                    64'(expected_idle), 64'(idle_cycles));
        check_value(test_name, "mux_out at frame start", 64'(expected_sel), 64'(mux_out));

        // Every sclk rise takes one bit per line, MSB first
        sclk_edges = 0;
        lat_cycle  = -1;
        cycles     = 0;
        prev_sclk  = 1'b0;
        while (lat_cycle < 0 && cycles <= 2 * word_bits + 4) begin
            if (drv.sclk && !prev_sclk) begin
                if (sclk_edges < word_bits) begin
                    samples[word_bits - 1 - sclk_edges] = drv.sin;
                end
                sclk_edges++;
            end
            if (driver_ready) begin
                report_error(test_name, "driver_ready went high in the middle of a shift");
            end
            prev_sclk = drv.sclk;
            if (drv.lat) begin
                lat_cycle = cycles;
            end else begin
                @(negedge clk_enable);
                cycles++;
            end
        end
        if (lat_cycle < 0) begin
            report_error(test_name, "no lat pulse followed the shift sequence");
            return;
        end
        check_value(test_name, "sclk rising edges", 64'(word_bits), 64'(sclk_edges));
        check_value(test_name, "cycle of lat pulse", 64'(2 * word_bits), 64'(lat_cycle));

        // All 30 lines carry the same word
        for (int d = 0; d < num_drivers; d++) begin
            for (int b = 0; b < word_bits; b++) begin
                line_word[b] = samples[b][d];
            end
            check_value(test_name, $sformatf("serial word on sin[%0d]", d),
                        64'(expected_word), 64'(line_word));
        end

        // The latched frame moves the column select one place left
        model_frames++;
        expected_sel = '0;
        expected_sel[model_frames % num_columns] = 1'b1;
        after_lat = 0;
        while (!driver_ready && after_lat < 8) begin
            @(negedge clk_enable);
            after_lat++;
        end
        check_value(test_name, "cycles from lat to driver_ready", 64'(2), 64'(after_lat));
        check_value(test_name, "mux_out after lat", 64'(expected_sel), 64'(mux_out));
    endtask

    // The run may take twice its nominal length before it counts as hung
    initial begin : watchdog
        longint total_frames;
        longint reset_count;
        longint limit_ns;
        total_frames = 0;
        reset_count  = 1;
        for (int t = 0; t < num_tests; t++) begin
            total_frames += test_table[t].frames;
            if (test_table[t].mid_reset) begin
                reset_count++;
            end
        end
        limit_ns = total_frames * sync_period * clk_period * 2
                 + reset_count * reset_cycles * clk_period;
        #(limit_ns);
        $display("ERROR: watchdog expired after %0d ns and stopped the run", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hef3f5a60));
        nrst = 1'b0;

        pulse_reset("power_on_reset", 1'b0);
        tests_run++;
        if (test_fails != 0) begin
            failed_tests++;
        end
        $display("test power_on_reset finished, %0d failed checks", test_fails);

        for (int t = 0; t < num_tests; t++) begin
            test_fails = 0;
            if (test_table[t].mid_reset) begin
                pulse_reset(test_table[t].name, 1'b1);
            end
            for (int f = 0; f < test_table[t].frames; f++) begin
                run_frame(test_table[t].name);
            end
            tests_run++;
            if (test_fails != 0) begin
                failed_tests++;
            end
            $display("test %s finished, %0d frames, %0d failed checks",
                     test_table[t].name, test_table[t].frames, test_fails);
        end

        // Counters of the free-running checks settle on the falling edge
        @(posedge clk_enable);
        test_fails = 0;
        check_value("free_running", "gclk toggles against cycles",
                    64'(gclk_cycles), 64'(gclk_toggles));
        if (uut.props.assert_failures != 0) begin
            report_error("free_running", $sformatf("%0d concurrent assertions failed",
                                                   uut.props.assert_failures));
        end
        tests_run++;
        if (test_fails != 0) begin
            failed_tests++;
        end
        $display("test free_running finished, %0d gclk cycles, %0d failed checks",
                 gclk_cycles, test_fails);

        $display("%0d tests run, %0d with failures, %0d checks, %0d errors",
                 tests_run, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verification/pov_display_properties.sv
/*
 * Protocol assertions for the POV display subsystem
 * Watches the driver pins, the ready level and the column select
 */
module pov_display_properties (
    input logic                 clk_enable,
    input logic                 nrst,
    input pov_pkg::driver_bus_t drv,
    input pov_pkg::column_sel_t mux_out,
    input logic                 driver_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    import pov_pkg::*;

    // Failures seen so far, read by the testbench at the end of the run
    int unsigned assert_failures = 0;

    // The drivers latch on lat, so it must never meet a shift clock
    lat_sclk_exclusive: assert property (
        @(posedge clk_enable) disable iff (!nrst) !(drv.lat && drv.sclk)
    ) else begin
        assert_failures++;
        $error("lat and sclk are high in the same cycle");
    end

    // Exactly one column is powered at a time
    mux_one_hot: assert property (
        @(posedge clk_enable) disable iff (!nrst) $onehot(mux_out)
    ) else begin
        assert_failures++;
        $error("mux_out is not one-hot: %b", mux_out);
    end

    // Shift clock and latch only show up while the controller is busy
    ready_low_while_busy: assert property (
        @(posedge clk_enable) disable iff (!nrst) (drv.sclk || drv.lat) |-> !driver_ready
    ) else begin
        assert_failures++;
        $error("driver_ready is high during a shift or latch");
    end

    // A transfer opens with a setup cycle and the first sclk follows it
    shift_starts_with_setup: assert property (
        @(posedge clk_enable) disable iff (!nrst) $fell(driver_ready) |=> drv.sclk
    ) else begin
        assert_failures++;
        $error("the first sclk does not follow the setup cycle");
    end

    // Ready returns two cycles after the latch, once the done cycle is over
    ready_after_latch: assert property (
        @(posedge clk_enable) disable iff (!nrst) $rose(driver_ready) |-> $past(drv.lat, 2)
    ) else begin
        assert_failures++;
        $error("driver_ready rose without a latch two cycles before");
    end

    // sin set up in ctl_setup holds through the sclk high cycle
    sin_stable_on_sclk: assert property (
        @(posedge clk_enable) disable iff (!nrst) drv.sclk |-> $stable(drv.sin)
    ) else begin
        assert_failures++;
        $error("sin changed while sclk was high");
    end

endmodule

bind pov_display_top pov_display_properties props (
    .clk_enable   (clk_enable),
    .nrst         (nrst),
    .drv          (drv),
    .mux_out      (mux_out),
    .driver_ready (driver_ready)
);

//--- hdl/pov_display_top.sv
/*
 * POV display subsystem top level
 * Ties the position pulse source, the test pattern, the driver controller
 * and the column multiplexer together on the single clock
 */
module pov_display_top (
    input  logic                 clk_enable,
    input  logic                 nrst,
    output pov_pkg::driver_bus_t drv,
    output pov_pkg::column_sel_t mux_out,
    output logic                 driver_ready
);
    import pov_pkg::*;

    // One pulse per angular step of the rotor
    logic         position_sync;
    // Word that every driver receives for the current column
    column_word_t column_word;
    // Marks the cycle after the latch of a column
    logic         column_ready;

    // Position source in place of the real hall sensor
    hall_sensor_emulator u_hall_sensor_emulator (
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .position_sync (position_sync)
    );

    // Moving dot pattern
    caterpillar_pattern u_caterpillar_pattern (
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .position_sync (position_sync),
        .column_word   (column_word)
    );

    // Serial transfer into the driver chain
    led_driver_controller u_led_driver_controller (
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .position_sync (position_sync),
        .column_word   (column_word),
        .drv           (drv),
        .column_ready  (column_ready),
        .driver_ready  (driver_ready)
    );

    // Column power switches
    column_mux u_column_mux (
        .clk_enable   (clk_enable),
        .nrst         (nrst),
        .column_ready (column_ready),
        .mux_out      (mux_out)
    );

endmodule

//--- hdl/column_mux.sv
/*
 * Column multiplexer
 * Keeps the one-hot select of the powered column and steps it forward
 * once the drivers hold the data of the next column
 */
module column_mux (
    input  logic                 clk_enable,
    input  logic                 nrst,
    input  logic                 column_ready,
    output pov_pkg::column_sel_t mux_out
);
    import pov_pkg::*;

    // Column 0 is powered first after reset
    // Each finished column moves the select one place left, wrapping
    // from the top column back to column 0
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            mux_out <= column_sel_t'(1);
        end else if (column_ready) begin
            mux_out <= {mux_out[num_columns-2:0], mux_out[num_columns-1]};
        end
    end

endmodule

//--- hdl/led_driver_controller.sv
/*
 * LED driver controller
 * Shifts one column word into every driver of the chain on a position pulse,
 * latches it and reports the finished column. The grayscale clock runs freely
 */
module led_driver_controller (
    input  logic                  clk_enable,
    input  logic                  nrst,
    input  logic                  position_sync,
    input  pov_pkg::column_word_t column_word,
    output pov_pkg::driver_bus_t  drv,
    output logic                  column_ready,
    output logic                  driver_ready
);
    import pov_pkg::*;

    shift_state_t   state;
    column_word_t   word_q;
    channel_index_t bit_cnt;
    logic           gclk_q;
    logic           shifting;

    // A new transfer only starts from idle
    // Position pulses seen in any other state are dropped
    logic start;
    assign start = (state == ctl_idle) && position_sync;

    // Capture of the column word on the start edge
    always_ff @(posedge clk_enable) begin
        if (start) begin
            word_q <= column_word;
        end
    end

    // Shift sequence
    // Each bit takes a setup cycle with sclk low and a clock cycle with
    // sclk high, MSB first, followed by one latch and one done cycle
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            state   <= ctl_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                ctl_idle: begin
                    if (position_sync) begin
                        state   <= ctl_setup;
                        bit_cnt <= channel_index_t'(word_bits - 1);
                    end
                end
                ctl_setup: begin
                    state <= ctl_clock;
                end
                ctl_clock: begin
                    // Bit 0 was just clocked in, so the word is complete
                    if (bit_cnt == '0) begin
                        state <= ctl_latch;
                    end else begin
                        state   <= ctl_setup;
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ctl_latch: begin
                    state <= ctl_done;
                end
                ctl_done: begin
                    state <= ctl_idle;
                end
                default: begin
                    state <= ctl_idle;
                end
            endcase
        end
    end

    // Grayscale clock toggles on every cycle, shifting or not
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            gclk_q <= 1'b0;
        end else begin
            gclk_q <= ~gclk_q;
        end
    end

    // Serial data is valid across the setup and clock cycles of a bit
    assign shifting = (state == ctl_setup) || (state == ctl_clock);

    // Driver pins come straight from the state register
    // All drivers show the same pattern, so every line gets the same bit
    always_comb begin
        drv.gclk = gclk_q;
        drv.sclk = (state == ctl_clock);
        drv.lat  = (state == ctl_latch);
        if (shifting) begin
            drv.sin = {num_drivers{word_q[bit_cnt]}};
        end else begin
            drv.sin = '0;
        end
    end

    // One-cycle notice to the column multiplexer after the latch
    assign column_ready = (state == ctl_done);

    // Ready for a new column only while idle
    assign driver_ready = (state == ctl_idle);

endmodule

//--- hdl/caterpillar_pattern.sv
/*
 * Caterpillar test pattern
 * Lights a single channel and moves it forward by one every few position
 * pulses, so a spinning display shows a slowly crawling dot
 */
module caterpillar_pattern (
    input  logic                 clk_enable,
    input  logic                 nrst,
    input  logic                 position_sync,
    output pov_pkg::column_word_t column_word
);
    import pov_pkg::*;

    // Width of the position pulse counter
    localparam int step_bits = $clog2(pattern_step);

    logic [step_bits-1:0] pulse_count;
    channel_index_t       lit_index;

    // Counts position pulses and advances the lit channel on every
    // pattern_step-th one
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            pulse_count <= '0;
            lit_index   <= '0;
        end else if (position_sync) begin
            if (pulse_count == step_bits'(pattern_step - 1)) begin
                pulse_count <= '0;
                // The last channel wraps back to the first one
                if (lit_index == channel_index_t'(word_bits - 1)) begin
                    lit_index <= '0;
                end else begin
                    lit_index <= lit_index + 1'b1;
                end
            end else begin
                pulse_count <= pulse_count + 1'b1;
            end
        end
    end

    // Only the indexed channel is set in the word
    // Since the index is a register the word follows one cycle after the pulse
    always_comb begin
        column_word = column_word_t'(1) << lit_index;
    end

endmodule

//--- hdl/hall_sensor_emulator.sv
/*
 * Hall sensor emulator
 * Produces one position pulse per angular step from a free-running counter
 */
module hall_sensor_emulator (
    input  logic clk_enable,
    input  logic nrst,
    output logic position_sync
);
    import pov_pkg::*;

    // Enough bits to count one full sync period
    localparam int count_bits = $clog2(sync_period);

    logic [count_bits-1:0] step_count;

    // The counter wraps after sync_period cycles, which stands in for
    // the time the rotor takes to move by one column
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            step_count <= '0;
        end else begin
            if (step_count == count_bits'(sync_period - 1)) begin
                step_count <= '0;
            end else begin
                step_count <= step_count + 1'b1;
            end
        end
    end

    // The pulse is high for the single cycle on the last count value
    // With the counter cleared at reset it first shows up sync_period-1
    // cycles after reset goes away
    assign position_sync = (step_count == count_bits'(sync_period - 1));

endmodule

//--- hdl/pov_pkg.sv
/*
 * POV display shared definitions
 * Sizes of the driver chain, the column multiplexer and the test pattern,
 * plus the vector types, the driver pin bundle and the controller states
 */
package pov_pkg;

    // Daisy-chained LED drivers, each with its own serial input
    localparam int num_drivers = 30;

    // Bits shifted into one driver per column, 16 channels of 3 colors
    localparam int word_bits = 48;

    // Columns switched by the multiplexer
    localparam int num_columns = 8;

    // Clock cycles between two position pulses
    // This has to stay above the 98 cycles a column transfer takes
    localparam int sync_period = 128;

    // Position pulses before the lit channel moves one step
    localparam int pattern_step = 4;

    // One column word for a single driver
    typedef logic [word_bits-1:0] column_word_t;

    // Index of a channel inside a column word, 0 to 47
    typedef logic [5:0] channel_index_t;

    // One-hot select of the active column
    typedef logic [num_columns-1:0] column_sel_t;

    // One serial data bit per driver
    typedef logic [num_drivers-1:0] sin_bus_t;

    // Every pin that goes to the driver chain
    typedef struct packed {
        logic     gclk;
        logic     sclk;
        logic     lat;
        sin_bus_t sin;
    } driver_bus_t;

    // States of the serial shift sequence
    typedef enum logic [2:0] {
        ctl_idle,
        ctl_setup,
        ctl_clock,
        ctl_latch,
        ctl_done
    } shift_state_t;

endpackage
